// File: dv/dcache_properties.sv
//////////////////////////////////////////////////
// Handshake assertions bound into the cache top
//////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_properties
  import dcache_pkg::*;
(
  input logic            clk_i,
  input logic            rst_ni,
  input logic            flush_i,
  input dcache_req_t     core_req_i,
  input logic            stall_o,
  input dcache_rsp_t     core_rsp_o,
  input dcache_mem_req_t mem_req_o,
  input dcache_rsp_t     mem_rsp_i
);

  int   fail_cnt = 0;
  logic rd_pend_q;
  int   rd_open_q;
  logic rd_strobe;
  logic rd_accept;

  assign rd_strobe = mem_req_o.valid & ~mem_req_o.we;
  // Read taken by setup this edge
  assign rd_accept = core_req_i.req & ~core_req_i.we & ~stall_o & ~flush_i;

  // Memory read in flight, and reads still owed a response
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_pend_q <= 1'b0;
      rd_open_q <= 0;
    end
    else
    begin
      if (rd_strobe)
        rd_pend_q <= 1'b1;
      else if (mem_rsp_i.valid)
        rd_pend_q <= 1'b0;
      rd_open_q <= rd_open_q + int'(rd_accept) - int'(core_rsp_o.valid);
    end
  end

  //////////////////////////////////////////////////
  // Assertions

  read_strobe_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rd_strobe |=> !mem_req_o.valid)
  else
  begin
    fail_cnt++;
    $error("Memory read strobe held longer than one cycle");
  end

  read_one_outstanding: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rd_pend_q |-> !rd_strobe)
  else
  begin
    fail_cnt++;
    $error("Second memory read issued while one is outstanding");
  end

  rsp_needs_read: assert property (
    @(posedge clk_i) disable iff (!rst_ni) core_rsp_o.valid |-> rd_open_q > 0)
  else
  begin
    fail_cnt++;
    $error("Core response without an accepted read");
  end

  // Covers the reset cycles and the first cycle after release
  stall_low_after_reset: assert property (
    @(posedge clk_i) !rst_ni |=> !stall_o)
  else
  begin
    fail_cnt++;
    $error("Stall high right after reset");
  end

endmodule

bind dcache_top dcache_properties u_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .flush_i    (flush_i),
  .core_req_i (core_req_i),
  .stall_o    (stall_o),
  .core_rsp_o (core_rsp_o),
  .mem_req_o  (mem_req_o),
  .mem_rsp_i  (mem_rsp_i)
);

// File: dv/dcache_tb.sv
//////////////////////////////////////////////////
// Random testbench for the data cache top level
// Memory model, cache-state model and compare tasks
//////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_tb
  import dcache_pkg::*;
();

  localparam int N_OPS      = 400;
  localparam int RST_CYC    = 16;
  localparam int MAX_DLY    = 4;
  // Worst op is a read miss, 4 cycles plus the memory delay
  localparam int CYC_LIMIT  = N_OPS * (4 + MAX_DLY) + RST_CYC + 100;
  localparam int MODEL_SETS = `DCACHE_SIZE * 8 / (`DCACHE_XLEN * `DCACHE_WAYS);
  localparam int MEM_WORDS  = 32;

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic            flush_i;
  dcache_req_t     core_req_i;
  logic            stall_o;
  dcache_rsp_t     core_rsp_o;
  dcache_mem_req_t mem_req_o;
  dcache_rsp_t     mem_rsp_i = '0;

  integer       seed     = 98454;
  int           cycles   = 0;
  int           mem_dly  = 1;
  int           rsp_wait = 0;
  dcache_wadr_t rsp_adr;
  dcache_word_t mem_words [MEM_WORDS];
  // Expected memory contents
  dcache_word_t ref_words [MEM_WORDS];

  // Cache-state model, per set and way
  int m_tag   [MODEL_SETS][2];
  bit m_valid [MODEL_SETS][2];
  int m_lru   [MODEL_SETS];

  always #4 clk_i = ~clk_i;

  dcache_top dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .core_req_i (core_req_i),
    .stall_o    (stall_o),
    .core_rsp_o (core_rsp_o),
    .mem_req_o  (mem_req_o),
    .mem_rsp_i  (mem_rsp_i)
  );

  //////////////////////////////////////////////////
  // Helpers

  // Odd multiplier keeps every word distinct
  function automatic dcache_word_t fill_word(input int w);
    return dcache_word_t'(w) * 32'h0103_0507 ^ 32'h5A5A_0000;
  endfunction

  function automatic dcache_word_t word_adr(input int w);
    return dcache_word_t'(w) << 2;
  endfunction

  function automatic dcache_word_t merge_bytes(input dcache_word_t old_w,
                                               input dcache_word_t new_w,
                                               input dcache_be_t   be);
    dcache_word_t res;
    res = old_w;
    for (int b = 0; b < `DCACHE_XLEN / 8; b++)
      if (be[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  // Way holding the word, -1 on a miss
  function automatic int model_way(input int w);
    int set;
    int tag;
    set = w % MODEL_SETS;
    tag = w / MODEL_SETS;
    for (int i = 0; i < 2; i++)
      if (m_valid[set][i] && m_tag[set][i] == tag)
        return i;
    return -1;
  endfunction

  task automatic check_rsp(input string name, input dcache_rsp_t exp, input dcache_rsp_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped");
    end
  endtask

  task automatic check_mem(input string name, input dcache_mem_req_t exp,
                           input dcache_mem_req_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped");
    end
  endtask

  //////////////////////////////////////////////////
  // Memory model

  // Writes land at once, reads answer mem_dly cycles after the strobe
  always @(posedge clk_i)
  begin
    mem_rsp_i <= '0;
    if (!rst_ni)
    begin
      for (int i = 0; i < MEM_WORDS; i++)
        mem_words[i] <= fill_word(i);
    end
    else if (mem_req_o.valid && mem_req_o.we)
      mem_words[mem_req_o.adr[4:0]] <= merge_bytes(mem_words[mem_req_o.adr[4:0]],
                                                   mem_req_o.data, mem_req_o.be);
    if (rsp_wait == 1)
      mem_rsp_i <= '{valid: 1'b1, data: mem_words[rsp_adr[4:0]]};
    if (rsp_wait > 0)
      rsp_wait <= rsp_wait - 1;
    if (mem_req_o.valid && !mem_req_o.we)
    begin
      rsp_wait <= mem_dly;
      rsp_adr  <= mem_req_o.adr;
    end
  end

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles > CYC_LIMIT)
    begin
      $display("Timeout after %0d cycles, the cache never finished", cycles);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped");
    end
  end

  // Bound assertions bump their counter on each failure
  always @(negedge clk_i)
  begin
    if (dut.u_props.fail_cnt != 0)
    begin
      $display("A bound handshake assertion failed in cycle %0d", cycles);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped");
    end
  end

  //////////////////////////////////////////////////
  // Operations

  task automatic read_word(input int w);
    int              way;
    int              set;
    int              victim;
    dcache_rsp_t     exp_rsp;
    dcache_mem_req_t exp_req;
    way     = model_way(w);
    set     = w % MODEL_SETS;
    exp_rsp = '{valid: 1'b1, data: ref_words[w]};
    @(posedge clk_i);
    core_req_i <= '{req: 1'b1, we: 1'b0, adr: word_adr(w), be: '1, data: '0};
    @(posedge clk_i);
    core_req_i <= '0;
    @(negedge clk_i);
    if (way >= 0)
    begin
      check_flag("read hit stall", 1'b0, stall_o);
      check_flag("read hit memory strobe", 1'b0, mem_req_o.valid);
      check_rsp("read hit data", exp_rsp, core_rsp_o);
      m_lru[set] = 1 - way;
    end
    else
    begin
      exp_req = '{valid: 1'b1, we: 1'b0, adr: dcache_wadr_t'(w), be: '1, data: '0};
      check_flag("read miss stall", 1'b1, stall_o);
      check_flag("read miss early response", 1'b0, core_rsp_o.valid);
      check_mem("read miss request", exp_req, mem_req_o);
      // Stall holds until the response, with no second strobe
      do
      begin
        @(negedge clk_i);
        check_flag("read miss repeated strobe", 1'b0, mem_req_o.valid);
        if (!core_rsp_o.valid)
          check_flag("refill stall", 1'b1, stall_o);
      end
      while (!core_rsp_o.valid);
      check_flag("read miss release", 1'b0, stall_o);
      check_rsp("read miss data", exp_rsp, core_rsp_o);
      // Invalid way first, else the LRU way
      victim = !m_valid[set][0] ? 0 : (!m_valid[set][1] ? 1 : m_lru[set]);
      m_valid[set][victim] = 1'b1;
      m_tag[set][victim]   = w / MODEL_SETS;
      m_lru[set]           = 1 - victim;
    end
  endtask

  task automatic write_word(input int w, input dcache_be_t be, input dcache_word_t data);
    int              way;
    dcache_mem_req_t exp_req;
    way     = model_way(w);
    exp_req = '{valid: 1'b1, we: 1'b1, adr: dcache_wadr_t'(w), be: be, data: data};
    @(posedge clk_i);
    core_req_i <= '{req: 1'b1, we: 1'b1, adr: word_adr(w), be: be, data: data};
    @(posedge clk_i);
    core_req_i <= '0;
    @(negedge clk_i);
    check_flag("write stall", 1'b0, stall_o);
    check_flag("write response", 1'b0, core_rsp_o.valid);
    check_mem("write request", exp_req, mem_req_o);
    ref_words[w] = merge_bytes(ref_words[w], data, be);
    // Hit way becomes MRU, a miss allocates nothing
    if (way >= 0)
      m_lru[w % MODEL_SETS] = 1 - way;
  endtask

  task automatic flush_cache();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    for (int s = 0; s < MODEL_SETS; s++)
    begin
      m_valid[s][0] = 1'b0;
      m_valid[s][1] = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    logic [31:0] rnd;
    int          w;
    for (int i = 0; i < MEM_WORDS; i++)
      ref_words[i] = fill_word(i);
    for (int s = 0; s < MODEL_SETS; s++)
    begin
      m_valid[s][0] = 1'b0;
      m_valid[s][1] = 1'b0;
      m_lru[s]      = 0;
    end
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    core_req_i = '0;
    repeat (RST_CYC) @(posedge clk_i);
    rst_ni <= 1'b1;

    // 16 words, four tags over four sets
    for (int n = 0; n < N_OPS; n++)
    begin
      rnd     = $random(seed);
      w       = int'(rnd[3:2]) * MODEL_SETS + int'(rnd[1:0]);
      mem_dly = 1 + int'(rnd[15:14]);
      if (rnd[8:4] == 5'd0)
        flush_cache();
      else if (rnd[9])
        write_word(w, rnd[13:10], $random(seed));
      else
        read_word(w);
    end

    @(negedge clk_i);
    if (dut.u_props.fail_cnt == 0)
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
    begin
      $display("Bound assertions failed %0d times", dut.u_props.fail_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped");
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it
# Exit status is zero only when the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module dcache_tb \
  -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Assertion errors are counted by the testbench instead of stopping the run
out=$(./obj_dir/dcache_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: src.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_setup.sv
verilog/dcache_array.sv
verilog/dcache_lookup.sv
verilog/dcache_top.sv
dv/dcache_properties.sv
dv/dcache_tb.sv

// File: verilog/dcache_array.sv
//////////////////////////////////////////////////
// Set-indexed storage with registered read port
// One instance per way for tags and for data
//////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_array
  import dcache_pkg::*;
#(
  parameter type entry_t = dcache_word_t,
  localparam int W       = $bits(entry_t),
  localparam int BE_W    = (W + 7) / 8
)
(
  input  logic            clk_i,
  input  dcache_idx_t     rd_idx_i,
  input  dcache_idx_t     wr_idx_i,
  input  logic            we_i,
  input  entry_t          wr_data_i,
  input  logic [BE_W-1:0] wr_be_i,
  output entry_t          rd_data_o
);

  entry_t       mem_q [SETS];
  logic [W-1:0] old_bits;
  logic [W-1:0] wr_bits;
  logic [W-1:0] new_bits;
  entry_t       wr_entry;

  // Byte merge of new data over the stored entry
  // Tag users tie all enables high
  always_comb
  begin
    old_bits = mem_q[wr_idx_i];
    wr_bits  = wr_data_i;
    for (int i = 0; i < W; i++)
      new_bits[i] = wr_be_i[i/8] ? wr_bits[i] : old_bits[i];
    wr_entry = entry_t'(new_bits);
  end

  // Read of the set being written returns the new entry
  always_ff @(posedge clk_i)
  begin
    if (we_i)
      mem_q[wr_idx_i] <= wr_entry;

    if (we_i && (wr_idx_i == rd_idx_i))
      rd_data_o <= wr_entry;
    else
      rd_data_o <= mem_q[rd_idx_i];
  end

endmodule

// File: verilog/dcache_cfg.svh
//////////////////////////////////////////////////
// Geometry of the data cache
// Included by the package and by the testbench
//////////////////////////////////////////////////

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Data and address width in bits
// Also the block size, one word per block
`define DCACHE_XLEN 32

// Total capacity in bytes
`define DCACHE_SIZE 64

// Associativity
// Lookup keeps a single LRU bit per set so only 2 works
`define DCACHE_WAYS 2

`endif

// File: verilog/dcache_lookup.sv
//////////////////////////////////////////////////
// Lookup stage with tag compare and way select
// Runs refills and write-through memory traffic
//////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_lookup
  import dcache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,

  input  dcache_stage_t           stage_i,
  input  dcache_wbuf_t            wbuf_i,

  // Array read data for the staged set
  input  dcache_tag_t  [WAYS-1:0] tag_rd_i,
  input  dcache_word_t [WAYS-1:0] dat_rd_i,

  // Shared array write port
  output logic         [WAYS-1:0] tag_we_o,
  output logic         [WAYS-1:0] dat_we_o,
  output dcache_tag_t             tag_wr_o,
  output dcache_word_t            dat_wr_o,
  output dcache_be_t              dat_be_o,
  output dcache_idx_t             wr_idx_o,

  output logic                    stall_o,
  output dcache_rsp_t             rsp_o,

  output dcache_mem_req_t         mem_req_o,
  input  dcache_rsp_t             mem_rsp_i
);

  typedef enum logic {ST_IDLE, ST_REFILL} state_t;

  //////////////////////////////////////////////////
  // Signals

  state_t          state_q;
  state_t          state_d;
  logic [WAYS-1:0] valid_q [SETS];
  // Per set the way to replace next
  logic            lru_q [SETS];
  logic            done_q;
  dcache_word_t    refill_q;

  logic [WAYS-1:0] hit_way;
  logic            hit;
  logic            hit_sel;
  logic            lookup_vld;
  logic            rd_hit;
  logic            rd_miss;
  logic            wr_req;
  logic            refill_we;
  logic            victim;

  //////////////////////////////////////////////////
  // Tag compare

  // Nothing is looked up during refill or in the response cycle after it
  assign lookup_vld = stage_i.req & (state_q == ST_IDLE) & ~done_q;

  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
      hit_way[w] = valid_q[stage_i.idx][w] & (tag_rd_i[w].tag == stage_i.tag);
  end

  assign hit     = |hit_way;
  assign hit_sel = hit_way[1];

  assign rd_hit  = lookup_vld & ~stage_i.we & hit;
  assign rd_miss = lookup_vld & ~stage_i.we & ~hit;
  assign wr_req  = lookup_vld & stage_i.we;

  // Invalid way first, else the LRU way
  always_comb
  begin
    if (!valid_q[stage_i.idx][0])
      victim = 1'b0;
    else if (!valid_q[stage_i.idx][1])
      victim = 1'b1;
    else
      victim = lru_q[stage_i.idx];
  end

  //////////////////////////////////////////////////
  // Refill FSM

  assign refill_we = (state_q == ST_REFILL) & mem_rsp_i.valid;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (rd_miss)
          state_d = ST_REFILL;
      ST_REFILL:
        if (mem_rsp_i.valid)
          state_d = ST_IDLE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
      for (int s = 0; s < SETS; s++)
      begin
        valid_q[s] <= '0;
        lru_q[s]   <= 1'b0;
      end
    end
    else
    begin
      state_q <= state_d;
      // Response pulse one cycle after the memory word
      done_q  <= refill_we;

      if (flush_i)
      begin
        for (int s = 0; s < SETS; s++)
          valid_q[s] <= '0;
      end
      else if (refill_we)
        valid_q[stage_i.idx][victim] <= 1'b1;

      // Fresh or hit way becomes MRU, read and write hits alike
      if (refill_we)
        lru_q[stage_i.idx] <= ~victim;
      else if ((rd_hit | wr_req) & hit)
        lru_q[stage_i.idx] <= ~hit_sel;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (refill_we)
      refill_q <= mem_rsp_i.data;
  end

  //////////////////////////////////////////////////
  // Array writes

  // Refill wins the port
  // Otherwise a write hit merges the write buffer
  always_comb
  begin
    tag_wr_o.tag = stage_i.tag;
    tag_we_o     = '0;
    if (refill_we)
    begin
      tag_we_o[victim] = 1'b1;
      dat_we_o         = '0;
      dat_we_o[victim] = 1'b1;
      dat_wr_o         = mem_rsp_i.data;
      dat_be_o         = '1;
      wr_idx_o         = stage_i.idx;
    end
    else
    begin
      dat_we_o = hit_way & {WAYS{wr_req & wbuf_i.we}};
      dat_wr_o = wbuf_i.data;
      dat_be_o = wbuf_i.be;
      wr_idx_o = wbuf_i.idx;
    end
  end

  //////////////////////////////////////////////////
  // Core and memory side

  assign stall_o = rd_miss | (state_q == ST_REFILL);

  assign rsp_o.valid = rd_hit | done_q;
  assign rsp_o.data  = done_q ? refill_q : dat_rd_i[hit_sel];

  // Every write goes out, reads only on a miss
  assign mem_req_o.valid = rd_miss | wr_req;
  assign mem_req_o.we    = stage_i.we;
  assign mem_req_o.adr   = {stage_i.tag, stage_i.idx};
  assign mem_req_o.be    = stage_i.be;
  assign mem_req_o.data  = stage_i.data;

endmodule

// File: verilog/dcache_pkg.sv
//////////////////////////////////////////////////
// Shared types and derived geometry of the cache
// Imported by every RTL module
//////////////////////////////////////////////////

`include "dcache_cfg.svh"

package dcache_pkg;

  //////////////////////////////////////////////////
  // Geometry helpers

  // Sets from capacity in bytes and block size in bits
  function automatic int no_of_sets(input int size, input int block_size, input int ways);
    return (size * 8) / (block_size * ways);
  endfunction

  // Byte offset bits inside one block
  function automatic int no_of_block_offset_bits(input int block_size);
    return $clog2(block_size / 8);
  endfunction

  function automatic int no_of_index_bits(input int sets);
    return $clog2(sets);
  endfunction

  // Whatever is left above index and offset
  function automatic int no_of_tag_bits(input int xlen, input int idx_bits, input int offs_bits);
    return xlen - idx_bits - offs_bits;
  endfunction

  localparam int XLEN       = `DCACHE_XLEN;
  localparam int WAYS       = `DCACHE_WAYS;
  localparam int BLOCK_SIZE = XLEN;
  localparam int SETS       = no_of_sets(`DCACHE_SIZE, BLOCK_SIZE, WAYS);
  localparam int OFFS_BITS  = no_of_block_offset_bits(BLOCK_SIZE);
  localparam int IDX_BITS   = no_of_index_bits(SETS);
  localparam int TAG_BITS   = no_of_tag_bits(XLEN, IDX_BITS, OFFS_BITS);

  //////////////////////////////////////////////////
  // Basic fields

  typedef logic [XLEN-1:0]           dcache_word_t;
  typedef logic [XLEN/8-1:0]         dcache_be_t;
  typedef logic [IDX_BITS-1:0]       dcache_idx_t;
  // Word address seen by memory
  typedef logic [XLEN-OFFS_BITS-1:0] dcache_wadr_t;

  //////////////////////////////////////////////////
  // Bundles

  // Core request, req low means idle
  typedef struct packed {
    logic         req;
    logic         we;
    dcache_word_t adr;
    dcache_be_t   be;
    dcache_word_t data;
  } dcache_req_t;

  // Request after setup with the address already split
  typedef struct packed {
    logic                req;
    logic                we;
    logic [TAG_BITS-1:0] tag;
    dcache_idx_t         idx;
    logic [OFFS_BITS-1:0] offs;
    dcache_be_t          be;
    dcache_word_t        data;
  } dcache_stage_t;

  // Read data strobe, core side and memory side alike
  typedef struct packed {
    logic         valid;
    dcache_word_t data;
  } dcache_rsp_t;

  typedef struct packed {
    logic         valid;
    logic         we;
    dcache_wadr_t adr;
    dcache_be_t   be;
    dcache_word_t data;
  } dcache_mem_req_t;

  // Tag array entry
  // Valid bits live in flops in lookup
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
  } dcache_tag_t;

  typedef struct packed {
    logic         we;
    dcache_idx_t  idx;
    dcache_word_t data;
    dcache_be_t   be;
  } dcache_wbuf_t;

endpackage

// File: verilog/dcache_setup.sv
//////////////////////////////////////////////////
// Address setup stage of the data cache
// Registers the core request and drives array indices
//////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_setup
  import dcache_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,

  input  logic          stall_i,
  input  logic          flush_i,
  input  dcache_req_t   req_i,

  output dcache_stage_t stage_o,
  output dcache_idx_t   idx_o,
  output dcache_wbuf_t  wbuf_o
);

  //////////////////////////////////////////////////
  // Signals

  dcache_idx_t   req_idx;
  logic          stage_req_q;
  dcache_stage_t stage_q;
  logic          wbuf_we_q;
  dcache_wbuf_t  wbuf_q;

  // Set index straight from the live address
  assign req_idx = req_i.adr[OFFS_BITS +: IDX_BITS];

  //////////////////////////////////////////////////
  // Control flops

  // Flush kills whatever enters the stage this cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      stage_req_q <= 1'b0;
      wbuf_we_q   <= 1'b0;
    end
    else if (flush_i)
    begin
      stage_req_q <= 1'b0;
      wbuf_we_q   <= 1'b0;
    end
    else if (!stall_i)
    begin
      stage_req_q <= req_i.req;
      wbuf_we_q   <= req_i.req & req_i.we;
    end
  end

  //////////////////////////////////////////////////
  // Payload flops

  // Held while stalled so lookup keeps seeing the missed request
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      stage_q.req  <= req_i.req;
      stage_q.we   <= req_i.we;
      stage_q.tag  <= req_i.adr[XLEN-1 -: TAG_BITS];
      stage_q.idx  <= req_idx;
      stage_q.offs <= req_i.adr[OFFS_BITS-1:0];
      stage_q.be   <= req_i.be;
      stage_q.data <= req_i.data;

      // Write buffer copy for the data array
      wbuf_q.we    <= req_i.req & req_i.we;
      wbuf_q.idx   <= req_idx;
      wbuf_q.data  <= req_i.data;
      wbuf_q.be    <= req_i.be;
    end
  end

  // Enables come from the reset flops
  always_comb
  begin
    stage_o     = stage_q;
    stage_o.req = stage_req_q;
    wbuf_o      = wbuf_q;
    wbuf_o.we   = wbuf_we_q;
  end

  // Arrays register the index themselves
  // While stalled they keep re-reading the held set
  assign idx_o = stall_i ? stage_q.idx : req_idx;

endmodule

// File: verilog/dcache_top.sv
//////////////////////////////////////////////////
// Data cache top level
// Setup stage, per-way arrays and lookup stage
//////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_top
  import dcache_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,

  // Core side
  input  dcache_req_t     core_req_i,
  output logic            stall_o,
  output dcache_rsp_t     core_rsp_o,

  // Memory side
  output dcache_mem_req_t mem_req_o,
  input  dcache_rsp_t     mem_rsp_i
);

  //////////////////////////////////////////////////
  // Wires

  dcache_stage_t           stage;
  dcache_idx_t             rd_idx;
  dcache_wbuf_t            wbuf;

  dcache_tag_t  [WAYS-1:0] tag_rd;
  dcache_word_t [WAYS-1:0] dat_rd;

  logic         [WAYS-1:0] tag_we;
  logic         [WAYS-1:0] dat_we;
  dcache_tag_t             tag_wr;
  dcache_word_t            dat_wr;
  dcache_be_t              dat_be;
  dcache_idx_t             wr_idx;

  //////////////////////////////////////////////////
  // Address setup

  dcache_setup u_setup (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .stall_i (stall_o),
    .flush_i (flush_i),
    .req_i   (core_req_i),
    .stage_o (stage),
    .idx_o   (rd_idx),
    .wbuf_o  (wbuf)
  );

  //////////////////////////////////////////////////
  // Tag and data arrays per way

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    // Tags are always written whole
    dcache_array #(
      .entry_t (dcache_tag_t)
    ) u_tag (
      .clk_i     (clk_i),
      .rd_idx_i  (rd_idx),
      .wr_idx_i  (wr_idx),
      .we_i      (tag_we[w]),
      .wr_data_i (tag_wr),
      .wr_be_i   ('1),
      .rd_data_o (tag_rd[w])
    );

    dcache_array #(
      .entry_t (dcache_word_t)
    ) u_dat (
      .clk_i     (clk_i),
      .rd_idx_i  (rd_idx),
      .wr_idx_i  (wr_idx),
      .we_i      (dat_we[w]),
      .wr_data_i (dat_wr),
      .wr_be_i   (dat_be),
      .rd_data_o (dat_rd[w])
    );
  end

  //////////////////////////////////////////////////
  // Lookup

  dcache_lookup u_lookup (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .stage_i   (stage),
    .wbuf_i    (wbuf),
    .tag_rd_i  (tag_rd),
    .dat_rd_i  (dat_rd),
    .tag_we_o  (tag_we),
    .dat_we_o  (dat_we),
    .tag_wr_o  (tag_wr),
    .dat_wr_o  (dat_wr),
    .dat_be_o  (dat_be),
    .wr_idx_o  (wr_idx),
    .stall_o   (stall_o),
    .rsp_o     (core_rsp_o),
    .mem_req_o (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
  );

endmodule
